// ==== hdl/backend_pkg.sv ====
package backend_pkg;

	// data word and byte address
	typedef logic [31:0] word_t;
	// register number, r0 reads as zero
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] op_t;

	localparam op_t OP_ADD = 4'd0;
	localparam op_t OP_SUB = 4'd1;
	localparam op_t OP_AND = 4'd2;
	localparam op_t OP_OR  = 4'd3;
	localparam op_t OP_XOR = 4'd4;
	localparam op_t OP_SLL = 4'd5;
	localparam op_t OP_SRL = 4'd6;
	localparam op_t OP_SLT = 4'd7;
	localparam op_t OP_LD  = 4'd8;
	localparam op_t OP_ST  = 4'd9;

	// pre-decoded instruction
	typedef struct packed {
		word_t    pc;
		op_t      op;
		reg_idx_t rd;
		reg_idx_t rj;
		reg_idx_t rk;
		word_t    imm;
		// second operand taken from imm
		logic     use_imm;
	} inst_t;

	// one forwarding source, pending while load data is outstanding
	typedef struct packed {
		logic     valid;
		reg_idx_t w_reg;
		word_t    data;
		logic     pending;
	} fwd_src_t;

	typedef struct packed {
		logic  req;
		logic  we;
		word_t addr;
		word_t wdata;
	} cache_bus_req_t;

	typedef struct packed {
		logic  ack;
		word_t rdata;
	} cache_bus_resp_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		logic     we;
		reg_idx_t w_reg;
		word_t    w_data;
	} commit_t;

	// index into the stall vectors
	typedef enum logic [1:0] {
		EX = 2'd0,
		M1 = 2'd1,
		M2 = 2'd2
	} stage_e;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_ACK,
		WAIT_LOW
	} mem_state_e;

	function automatic logic is_mem(input op_t op);
		return (op == OP_LD) || (op == OP_ST);
	endfunction

	// stores write nothing, r0 writes are dropped
	function automatic logic writes_rd(input inst_t inst);
		return (inst.op != OP_ST) && (inst.rd != '0);
	endfunction

	// rk is the store data, or the second alu operand without imm
	function automatic logic reads_rk(input inst_t inst);
		return (inst.op == OP_ST) || (!inst.use_imm && !is_mem(inst.op));
	endfunction

endpackage

// ==== hdl/issue.sv ====
`timescale 1ns/1ps

module issue import backend_pkg::*; (
	input  inst_t [1:0] inst_i,
	input  logic  [1:0] inst_valid_i,
	input  logic        stall_i,
	output logic  [1:0] issue_o,
	output logic        revert_o
);

	logic [1:0] mem_op;
	logic       raw_rj;
	logic       raw_rk;
	logic       pair_ok;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			mem_op[i] = is_mem(inst_i[i].op);
		end
	end

	// younger reads what the older one writes
	assign raw_rj = writes_rd(inst_i[0]) && (inst_i[1].rj == inst_i[0].rd);
	assign raw_rk = writes_rd(inst_i[0]) && reads_rk(inst_i[1])
		&& (inst_i[1].rk == inst_i[0].rd);

	// only one memory port, so never two mem ops together
	assign pair_ok = inst_valid_i[1] && !raw_rj && !raw_rk && !(&mem_op);

	// in order only, so 00, 01 or 11
	always_comb begin
		issue_o = 2'b00;
		if (!stall_i && inst_valid_i[0]) begin
			issue_o[0] = 1'b1;
			issue_o[1] = pair_ok;
		end
	end

	// younger mem op has to sit in pipe 0, older goes to pipe 1
	assign revert_o = inst_valid_i[1] && mem_op[1] && !mem_op[0];

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import backend_pkg::*; (
	input  logic           clk,
	input  logic           arst_n_i,
	input  logic     [1:0] w_en_i,
	input  reg_idx_t [1:0] w_ptr_i,
	input  word_t    [1:0] w_data_i,
	input  reg_idx_t [3:0] r_ptr_i,
	output word_t    [3:0] r_data_o
);

	word_t [31:0] regs_q;
	logic  [1:0]  w_act;

	// r0 never gets written
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			w_act[w] = w_en_i[w] && (w_ptr_i[w] != '0);
		end
	end

	// port 1 last, younger write wins
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			regs_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (w_act[w]) regs_q[w_ptr_i[w]] <= w_data_i[w];
			end
		end
	end

	// write-through, same priority as the write
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			r_data_o[r] = regs_q[r_ptr_i[r]];
			for (int w = 0; w < 2; w++) begin
				if (w_act[w] && (w_ptr_i[w] == r_ptr_i[r])) r_data_o[r] = w_data_i[w];
			end
		end
	end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu import backend_pkg::*; (
	input  op_t   op_i,
	input  word_t a_i,
	input  word_t b_i,
	output word_t result_o
);

	logic [4:0] shamt;
	logic       less;

	// shifts use the low five bits only
	assign shamt = b_i[4:0];
	// signed compare for slt
	assign less  = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			OP_ADD: result_o = a_i + b_i;
			OP_SUB: result_o = a_i - b_i;
			OP_AND: result_o = a_i & b_i;
			OP_OR:  result_o = a_i | b_i;
			OP_XOR: result_o = a_i ^ b_i;
			OP_SLL: result_o = a_i << shamt;
			OP_SRL: result_o = a_i >> shamt;
			OP_SLT: result_o = word_t'(less);
			// effective address, rj plus imm
			OP_LD,
			OP_ST:  result_o = a_i + b_i;
			default: result_o = '0;
		endcase
	end

endmodule

// ==== hdl/mem_port.sv ====
`timescale 1ns/1ps

module mem_port import backend_pkg::*; (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            start_i,
	input  logic            we_i,
	input  word_t           addr_i,
	input  word_t           wdata_i,
	output logic            done_o,
	output word_t           rdata_o,
	output cache_bus_req_t  bus_req_o,
	input  cache_bus_resp_t bus_resp_i
);

	mem_state_e state_q;
	logic       req_q;
	logic       done_q;
	logic       we_q;
	word_t      addr_q;
	word_t      wdata_q;
	word_t      rdata_q;

	// four-phase handshake, req up, ack up, req down, ack down
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			req_q   <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			// done lasts a single cycle
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start_i) begin
						req_q   <= 1'b1;
						state_q <= WAIT_ACK;
					end
				end
				WAIT_ACK: begin
					if (bus_resp_i.ack) begin
						req_q   <= 1'b0;
						done_q  <= 1'b1;
						state_q <= WAIT_LOW;
					end
				end
				// no new start until ack is gone
				WAIT_LOW: begin
					if (!bus_resp_i.ack) state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// request held stable while req is high
	always_ff @(posedge clk) begin
		if (state_q == IDLE && start_i) begin
			we_q    <= we_i;
			addr_q  <= addr_i;
			wdata_q <= wdata_i;
		end
		if (state_q == WAIT_ACK && bus_resp_i.ack) rdata_q <= bus_resp_i.rdata;
	end

	assign bus_req_o = '{req: req_q, we: we_q, addr: addr_q, wdata: wdata_q};
	assign done_o    = done_q;
	assign rdata_o   = rdata_q;

endmodule

// ==== hdl/backend_pipeline.sv ====
`timescale 1ns/1ps

module backend_pipeline import backend_pkg::*; #(
	parameter bit MAIN_PIPE = 1'b1
) (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic            [2:0] stall_vec_i,
	input  logic                  issue_i,
	input  logic                  revert_i,
	input  inst_t                 inst_i,
	input  word_t           [1:0] reg_data_i,
	input  fwd_src_t        [3:0] fwd_src_i,
	input  logic            [1:0] fwd_young_i,
	output logic                  ex_stall_req_o,
	output logic                  m1_stall_req_o,
	output fwd_src_t              fwd_m1_o,
	output fwd_src_t              fwd_m2_o,
	output logic                  reg_w_en_o,
	output reg_idx_t              reg_w_addr_o,
	output word_t                 reg_w_data_o,
	output commit_t               commit_o,
	output logic                  m2_revert_o,
	output cache_bus_req_t        bus_req_o,
	input  cache_bus_resp_t       bus_resp_i
);

	// operand 0 is rj, operand 1 is rk
	typedef struct packed {
		logic        revert;
		inst_t       inst;
		word_t [1:0] opnd;
	} ex_stage_t;

	typedef struct packed {
		logic  revert;
		inst_t inst;
		word_t result;
		word_t st_data;
	} m1_stage_t;

	typedef struct packed {
		logic  revert;
		inst_t inst;
		word_t result;
	} m2_stage_t;

	logic      [2:0]      vld_q;
	ex_stage_t            ex_q;
	m1_stage_t            m1_q;
	m2_stage_t            m2_q;
	logic      [3:0][1:0] fwd_order;
	reg_idx_t  [1:0]      ex_src;
	word_t     [1:0]      opnd;
	logic      [1:0]      opnd_pend;
	word_t                alu_b;
	word_t                alu_result;
	logic                 m1_mem;
	logic                 m1_ld;
	logic                 mem_done;
	word_t                mem_rdata;

	assign ex_src = {ex_q.inst.rk, ex_q.inst.rj};

	// source index is stage * 2 + pipe, youngest first
	assign fwd_order[0] = {1'b0, fwd_young_i[0]};
	assign fwd_order[1] = {1'b0, ~fwd_young_i[0]};
	assign fwd_order[2] = {1'b1, fwd_young_i[1]};
	assign fwd_order[3] = {1'b1, ~fwd_young_i[1]};

	// walk oldest to youngest, last hit wins
	always_comb begin : fwd_sel
		fwd_src_t src;
		for (int k = 0; k < 2; k++) begin
			opnd[k]      = ex_q.opnd[k];
			opnd_pend[k] = 1'b0;
			for (int i = 3; i >= 0; i--) begin
				src = fwd_src_i[fwd_order[i]];
				if (src.valid && (src.w_reg == ex_src[k])) begin
					opnd[k]      = src.data;
					opnd_pend[k] = src.pending;
				end
			end
		end
	end

	// load-use, wait for the data
	assign ex_stall_req_o = vld_q[EX]
		&& (opnd_pend[0] || (reads_rk(ex_q.inst) && opnd_pend[1]));

	// mem ops always take imm as offset
	assign alu_b = (ex_q.inst.use_imm || is_mem(ex_q.inst.op)) ? ex_q.inst.imm : opnd[1];

	alu alu_module (
		.op_i    (ex_q.inst.op),
		.a_i     (opnd[0]),
		.b_i     (alu_b),
		.result_o(alu_result)
	);

	// stage valids, bubble behind a stalled stage
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vld_q <= '0;
		end else begin
			if (!stall_vec_i[EX]) vld_q[EX] <= issue_i;
			if (!stall_vec_i[M1]) vld_q[M1] <= vld_q[EX] && !stall_vec_i[EX];
			if (!stall_vec_i[M2]) vld_q[M2] <= vld_q[M1] && !stall_vec_i[M1];
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_vec_i[EX]) begin
			ex_q.revert <= revert_i;
			ex_q.inst   <= inst_i;
			ex_q.opnd   <= reg_data_i;
		end else begin
			// held in EX, keep catching producers before they retire
			ex_q.opnd <= opnd;
		end
		if (!stall_vec_i[M1]) begin
			m1_q.revert  <= ex_q.revert;
			m1_q.inst    <= ex_q.inst;
			m1_q.result  <= alu_result;
			m1_q.st_data <= opnd[1];
		end
		if (!stall_vec_i[M2]) begin
			m2_q.revert <= m1_q.revert;
			m2_q.inst   <= m1_q.inst;
			m2_q.result <= m1_ld ? mem_rdata : m1_q.result;
		end
	end

	// M1, memory access on the main pipe only
	assign m1_mem = MAIN_PIPE && vld_q[M1] && is_mem(m1_q.inst.op);
	assign m1_ld  = m1_mem && (m1_q.inst.op == OP_LD);
	assign m1_stall_req_o = m1_mem && !mem_done;

	if (MAIN_PIPE) begin : g_mem
		mem_port mem_port_module (
			.clk,
			.arst_n_i,
			.start_i   (m1_mem),
			.we_i      (m1_q.inst.op == OP_ST),
			.addr_i    (m1_q.result),
			.wdata_i   (m1_q.st_data),
			.done_o    (mem_done),
			.rdata_o   (mem_rdata),
			.bus_req_o,
			.bus_resp_i
		);
	end else begin : g_no_mem
		assign mem_done  = 1'b0;
		assign mem_rdata = '0;
		assign bus_req_o = '0;
	end

	assign fwd_m1_o = '{
		valid:   vld_q[M1] && writes_rd(m1_q.inst),
		w_reg:   m1_q.inst.rd,
		data:    m1_ld ? mem_rdata : m1_q.result,
		pending: m1_ld && !mem_done
	};

	// M2, register write and commit in the same cycle
	assign fwd_m2_o = '{
		valid:   vld_q[M2] && writes_rd(m2_q.inst),
		w_reg:   m2_q.inst.rd,
		data:    m2_q.result,
		pending: 1'b0
	};

	assign reg_w_en_o   = fwd_m2_o.valid;
	assign reg_w_addr_o = m2_q.inst.rd;
	assign reg_w_data_o = m2_q.result;
	assign m2_revert_o  = m2_q.revert;

	assign commit_o = '{
		valid:  vld_q[M2],
		pc:     m2_q.inst.pc,
		we:     writes_rd(m2_q.inst),
		w_reg:  m2_q.inst.rd,
		w_data: m2_q.result
	};

endmodule

// ==== hdl/backend.sv ====
`timescale 1ns/1ps

module backend import backend_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  inst_t           [1:0] inst_i,
	input  logic            [1:0] inst_valid_i,
	output logic            [1:0] issue_num_o,
	output logic                  backend_stall_o,
	output cache_bus_req_t        bus_req_o,
	input  cache_bus_resp_t       bus_resp_i,
	output commit_t         [1:0] commit_o
);

	logic     [1:0]      issue;
	logic                revert;
	inst_t    [1:0]      pipe_inst;
	logic     [1:0]      pipe_issue;
	logic     [2:0]      stall_vec;
	logic     [1:0][2:0] stall_req;
	reg_idx_t [3:0]      reg_r_addr;
	word_t    [3:0]      reg_r_data;
	logic     [1:0]      reg_w_en;
	reg_idx_t [1:0]      reg_w_addr;
	word_t    [1:0]      reg_w_data;
	logic     [1:0]      w_en;
	reg_idx_t [1:0]      w_addr;
	word_t    [1:0]      w_data;
	fwd_src_t [3:0]      fwd_src;
	logic     [1:0]      fwd_young;
	commit_t  [1:0]      pipe_commit;
	logic                m2_revert;
	logic                ex_revert_q;
	logic                m1_revert_q;

	issue issue_module (
		.inst_i      (inst_i),
		.inst_valid_i(inst_valid_i),
		.stall_i     (stall_vec[EX]),
		.issue_o     (issue),
		.revert_o    (revert)
	);

	// 0, 1 or 2 taken
	assign issue_num_o = {issue[1], issue[0] & ~issue[1]};

	// with revert, pipe 0 gets the younger one
	for (genvar p = 0; p < 2; p++) begin : g_steer
		assign pipe_inst[p]       = inst_i[revert ^ 1'(p)];
		assign pipe_issue[p]      = issue[revert ^ 1'(p)];
		assign reg_r_addr[2*p]    = pipe_inst[p].rj;
		assign reg_r_addr[2*p+1]  = pipe_inst[p].rk;
	end

	// write port 1 is the younger M2 entry
	always_comb begin
		for (int a = 0; a < 2; a++) begin
			w_en[a]     = reg_w_en[a ^ int'(m2_revert)];
			w_addr[a]   = reg_w_addr[a ^ int'(m2_revert)];
			w_data[a]   = reg_w_data[a ^ int'(m2_revert)];
			commit_o[a] = pipe_commit[a ^ int'(m2_revert)];
		end
	end

	reg_file reg_file_module (
		.clk,
		.arst_n_i,
		.w_en_i  (w_en),
		.w_ptr_i (w_addr),
		.w_data_i(w_data),
		.r_ptr_i (reg_r_addr),
		.r_data_o(reg_r_data)
	);

	// revert of the pair now in M1, M2 comes from the pipe
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_revert_q <= 1'b0;
			m1_revert_q <= 1'b0;
		end else begin
			if (!stall_vec[EX]) ex_revert_q <= revert;
			if (!stall_vec[M1]) m1_revert_q <= ex_revert_q;
		end
	end

	// index of the younger pipe per stage
	assign fwd_young = {~m2_revert, ~m1_revert_q};

	backend_pipeline #(
		.MAIN_PIPE(1'b1)
	) pipeline_0 (
		.clk,
		.arst_n_i,
		.stall_vec_i   (stall_vec),
		.issue_i       (pipe_issue[0]),
		.revert_i      (revert),
		.inst_i        (pipe_inst[0]),
		.reg_data_i    (reg_r_data[1:0]),
		.fwd_src_i     (fwd_src),
		.fwd_young_i   (fwd_young),
		.ex_stall_req_o(stall_req[0][EX]),
		.m1_stall_req_o(stall_req[0][M1]),
		.fwd_m1_o      (fwd_src[0]),
		.fwd_m2_o      (fwd_src[2]),
		.reg_w_en_o    (reg_w_en[0]),
		.reg_w_addr_o  (reg_w_addr[0]),
		.reg_w_data_o  (reg_w_data[0]),
		.commit_o      (pipe_commit[0]),
		.m2_revert_o   (m2_revert),
		.bus_req_o,
		.bus_resp_i
	);

	backend_pipeline #(
		.MAIN_PIPE(1'b0)
	) pipeline_1 (
		.clk,
		.arst_n_i,
		.stall_vec_i   (stall_vec),
		.issue_i       (pipe_issue[1]),
		.revert_i      (revert),
		.inst_i        (pipe_inst[1]),
		.reg_data_i    (reg_r_data[3:2]),
		.fwd_src_i     (fwd_src),
		.fwd_young_i   (fwd_young),
		.ex_stall_req_o(stall_req[1][EX]),
		.m1_stall_req_o(stall_req[1][M1]),
		.fwd_m1_o      (fwd_src[1]),
		.fwd_m2_o      (fwd_src[3]),
		.reg_w_en_o    (reg_w_en[1]),
		.reg_w_addr_o  (reg_w_addr[1]),
		.reg_w_data_o  (reg_w_data[1]),
		.commit_o      (pipe_commit[1]),
		.m2_revert_o   (),
		.bus_req_o     (),
		.bus_resp_i    ('0)
	);

	// M2 never asks to stall
	assign stall_req[0][M2] = 1'b0;
	assign stall_req[1][M2] = 1'b0;

	// a request stalls its own stage and everything before it, both pipes
	always_comb begin
		for (int lv = 0; lv < 3; lv++) begin
			stall_vec[lv] = 1'b0;
			for (int rq = lv; rq < 3; rq++) begin
				stall_vec[lv] |= stall_req[0][rq] | stall_req[1][rq];
			end
		end
	end

	assign backend_stall_o = stall_vec[EX];

endmodule

// ==== tests/backend_ref.svh ====
`ifndef BACKEND_REF_SVH
`define BACKEND_REF_SVH

// expected alu value straight from the opcode table
function automatic word_t alu_result(input op_t op, input word_t a, input word_t b);
	case (op)
		OP_ADD: return a + b;
		OP_SUB: return a - b;
		OP_AND: return a & b;
		OP_OR:  return a | b;
		OP_XOR: return a ^ b;
		// shift amount is the low five bits
		OP_SLL: return a << b[4:0];
		OP_SRL: return a >> b[4:0];
		OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		default: return 32'd0;
	endcase
endfunction

// number of instructions the pairing rules let through, given the EX stall
function automatic logic [1:0] expected_issue(input inst_t older, input inst_t younger,
		input logic [1:0] valid, input logic stall);
	logic older_mem;
	logic younger_mem;
	logic younger_rk;
	logic hazard;
	if (stall || !valid[0]) return 2'd0;
	older_mem   = (older.op == OP_LD) || (older.op == OP_ST);
	younger_mem = (younger.op == OP_LD) || (younger.op == OP_ST);
	// rk is read as store data or as the second alu operand
	younger_rk  = (younger.op == OP_ST) || (!younger_mem && !younger.use_imm);
	// younger reads a register the older one writes
	hazard      = (older.op != OP_ST) && (older.rd != 5'd0)
		&& ((younger.rj == older.rd) || (younger_rk && (younger.rk == older.rd)));
	if (!valid[1] || hazard || (older_mem && younger_mem)) return 2'd1;
	return 2'd2;
endfunction

// runs one instruction on model_regs and model_mem
// returns the commit record it has to produce
function automatic commit_t execute_inst(input inst_t inst);
	word_t   a;
	word_t   b;
	word_t   addr;
	commit_t c;
	a        = model_regs[inst.rj];
	b        = inst.use_imm ? inst.imm : model_regs[inst.rk];
	// mem address is rj plus imm, one of 64 words
	addr     = a + inst.imm;
	c.valid  = 1'b1;
	c.pc     = inst.pc;
	c.we     = (inst.op != OP_ST) && (inst.rd != 5'd0);
	c.w_reg  = inst.rd;
	if (inst.op == OP_LD) begin
		c.w_data = model_mem[addr[7:2]];
	end else if (inst.op == OP_ST) begin
		model_mem[addr[7:2]] = model_regs[inst.rk];
		c.w_data = addr;
	end else begin
		c.w_data = alu_result(inst.op, a, b);
	end
	// r0 keeps zero
	if (c.we) model_regs[inst.rd] = c.w_data;
	return c;
endfunction

`endif

// ==== tests/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb import backend_pkg::*; ();

	localparam int N_INST      = 400;
	localparam int MEM_WORDS   = 64;
	// full pipe plus a slow bus transfer per instruction, plus slack
	localparam int CYCLE_LIMIT = N_INST * (3 + 6) + 100;

	logic            clk;
	logic            arst_n_i;
	inst_t     [1:0] inst;
	logic      [1:0] inst_valid;
	logic      [1:0] issue_num;
	logic            backend_stall;
	cache_bus_req_t  bus_req;
	cache_bus_resp_t bus_resp;
	commit_t   [1:0] commit;

	inst_t   prog [N_INST];
	commit_t expected_q [$];
	word_t   model_regs [32];
	word_t   model_mem [MEM_WORDS];
	word_t   bus_mem [MEM_WORDS];
	int      mismatches   = 0;
	int      other_errors = 0;
	int      commits      = 0;
	int      cycles       = 0;
	int      ptr          = 0;
	logic    req_prev;
	logic    ack_prev;

	`include "backend_ref.svh"

	backend i_dut (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.inst_i         (inst),
		.inst_valid_i   (inst_valid),
		.issue_num_o    (issue_num),
		.backend_stall_o(backend_stall),
		.bus_req_o      (bus_req),
		.bus_resp_i     (bus_resp),
		.commit_o       (commit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	task automatic check_value(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			mismatches++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// random ops over r0..r7, mem ops use imm as the word offset
	task automatic make_program();
		op_t op;
		for (int i = 0; i < N_INST; i++) begin
			op = op_t'($urandom_range(0, 9));
			prog[i].pc = word_t'(i * 4);
			prog[i].op = op;
			prog[i].rd = reg_idx_t'($urandom_range(0, 7));
			prog[i].rj = reg_idx_t'($urandom_range(0, 7));
			prog[i].rk = reg_idx_t'($urandom_range(0, 7));
			if (op == OP_LD || op == OP_ST) begin
				prog[i].use_imm = 1'b1;
				prog[i].imm     = word_t'($urandom_range(0, MEM_WORDS - 1) * 4);
			end else begin
				prog[i].use_imm = 1'($urandom_range(0, 1));
				prog[i].imm     = $urandom();
			end
		end
	endtask

	// older one in slot 0, invalid past the end
	task automatic present_pair(input int idx);
		for (int k = 0; k < 2; k++) begin
			if (idx + k < N_INST) begin
				inst[k]       = prog[idx + k];
				inst_valid[k] = 1'b1;
			end else begin
				inst[k]       = '0;
				inst_valid[k] = 1'b0;
			end
		end
	endtask

	initial begin
		void'($urandom(32'ha953));
		arst_n_i   = 1'b0;
		inst       = '0;
		inst_valid = 2'b00;
		bus_resp   = '0;
		req_prev   = 1'b0;
		ack_prev   = 1'b0;
		for (int r = 0; r < 32; r++) model_regs[r] = '0;
		// fill depends on the full word address
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
			bus_mem[i]   = model_mem[i];
		end
		make_program();
		// whole program on the model, in order
		for (int i = 0; i < N_INST; i++) expected_q.push_back(execute_inst(prog[i]));
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;
		// quiet outputs before the first instruction
		repeat (3) begin
			@(posedge clk);
			check_value("commit_o[0].valid", word_t'(commit[0].valid), '0);
			check_value("commit_o[1].valid", word_t'(commit[1].valid), '0);
			check_value("bus_req_o.req", word_t'(bus_req.req), '0);
			check_value("backend_stall_o", word_t'(backend_stall), '0);
		end
		while (commits < N_INST && cycles < CYCLE_LIMIT) @(posedge clk);
		if (commits < N_INST) begin
			other_errors++;
			$display("timeout: %0d of %0d instructions committed after %0d cycles",
				commits, N_INST, cycles);
		end
		// stray commits after the program land in the checker
		repeat (20) @(posedge clk);
		for (int i = 0; i < MEM_WORDS; i++) begin
			check_value($sformatf("bus_mem[%0d]", i), bus_mem[i], model_mem[i]);
		end
		$display("mismatches %0d, other errors %0d, commits %0d of %0d",
			mismatches, other_errors, commits, N_INST);
		if (mismatches == 0 && other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// frontend, advances by issue_num sampled at the rising edge
	initial begin : feed
		int taken;
		@(posedge arst_n_i);
		repeat (3) @(negedge clk);
		forever begin
			present_pair(ptr);
			@(posedge clk);
			taken = int'(issue_num);
			// pairing rules under the EX stall of this cycle
			check_value("issue_num_o", word_t'(issue_num),
				word_t'(expected_issue(inst[0], inst[1], inst_valid, backend_stall)));
			@(negedge clk);
			ptr += taken;
		end
	end

	// bus memory, 0 to 4 cycles to ack, ack held until req drops
	initial begin : responder
		int         delay;
		logic [5:0] idx;
		forever begin
			@(negedge clk);
			if (bus_req.req && !bus_resp.ack) begin
				delay = int'($urandom_range(0, 4));
				repeat (delay) @(negedge clk);
				idx = bus_req.addr[7:2];
				if (bus_req.we) bus_mem[idx] = bus_req.wdata;
				bus_resp.rdata = bus_mem[idx];
				bus_resp.ack   = 1'b1;
				while (bus_req.req) @(negedge clk);
				bus_resp.ack = 1'b0;
			end
		end
	end

	// four-phase rules seen from the bus, ack_prev is ack at the edge req changed
	always @(posedge clk) begin
		if (arst_n_i) begin
			if (req_prev && !bus_req.req && !ack_prev) begin
				other_errors++;
				$display("bus req dropped at %0t ns before ack came", $time);
			end
			if (!req_prev && bus_req.req && ack_prev) begin
				other_errors++;
				$display("bus req rose at %0t ns while ack was still high", $time);
			end
		end
		req_prev <= bus_req.req;
		ack_prev <= bus_resp.ack;
	end

	// slot 0 is the older record, compared first
	always @(posedge clk) begin : commit_check
		commit_t want;
		if (arst_n_i) begin
			for (int k = 0; k < 2; k++) begin
				if (commit[k].valid) begin
					if (expected_q.size() == 0) begin
						other_errors++;
						$display("commit of pc %h at %0t ns with nothing left to commit",
							commit[k].pc, $time);
					end else begin
						want = expected_q.pop_front();
						check_value($sformatf("commit_o[%0d].pc", k), commit[k].pc, want.pc);
						check_value($sformatf("commit_o[%0d].we", k),
							word_t'(commit[k].we), word_t'(want.we));
						// reg and data only mean something on a write
						if (want.we) begin
							check_value($sformatf("commit_o[%0d].w_reg", k),
								word_t'(commit[k].w_reg), word_t'(want.w_reg));
							check_value($sformatf("commit_o[%0d].w_data", k),
								commit[k].w_data, want.w_data);
						end
						commits++;
					end
				end
			end
		end
	end

endmodule

// ==== backend.f ====
+incdir+tests
hdl/backend_pkg.sv
hdl/issue.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/mem_port.sv
hdl/backend_pipeline.sv
hdl/backend.sv
tests/backend_tb.sv

// ==== Makefile ====
# Verilator build and run of the backend testbench

VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= backend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
